// File: files.f
logic/rv5Pkg.sv
logic/controlDecoder.sv
logic/regFile.sv
logic/hazardUnit.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/memWbStage.sv
logic/rv5Core.sv
verif/rv5CoreTb.sv
+incdir+include

// File: logic/controlDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module controlDecoder import rv5Pkg::*; (
    input  wire word_t instr,
    output pcSel_t     pcSel,
    output op1Sel_t    op1Sel,
    output op2Sel_t    op2Sel,
    output aluOp_t     aluOp,
    output logic       linkSel,
    output memWbSel_t  memWbSel,
    output logic       memRead,
    output logic       memWrite,
    output logic       regWrite,
    output logic       isBeq,
    output logic       isBne
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;
    logic       isShift;
    aluOp_t     aluFunc;

    assign opcode  = instr[6:0];
    assign funct3  = instr[14:12];
    // funct7 bit 5 picks sub and sra
    assign alt     = instr[30];
    assign isShift = (funct3 == 3'b001) || (funct3 == 3'b101);

    always_comb begin
        case (funct3)
            3'b000:  aluFunc = AluAdd;
            3'b001:  aluFunc = AluSll;
            3'b010:  aluFunc = AluSlt;
            3'b011:  aluFunc = AluSltu;
            3'b100:  aluFunc = AluXor;
            3'b101:  aluFunc = alt ? AluSra : AluSrl;
            3'b110:  aluFunc = AluOr;
            default: aluFunc = AluAnd;
        endcase
    end

    always_comb begin
        // bubble unless the opcode is recognized
        pcSel    = PcPlus4;
        op1Sel   = Op1Rs1;
        op2Sel   = Op2Rs2;
        aluOp    = AluAdd;
        linkSel  = 1'b0;
        memWbSel = WbAlu;
        memRead  = 1'b0;
        memWrite = 1'b0;
        regWrite = 1'b0;
        isBeq    = 1'b0;
        isBne    = 1'b0;
        case (opcode)
            OpcOp: begin
                regWrite = 1'b1;
                aluOp    = (funct3 == 3'b000 && alt) ? AluSub : aluFunc;
            end
            OpcOpImm: begin
                regWrite = 1'b1;
                aluOp    = aluFunc;
                op2Sel   = isShift ? Op2Shamt : Op2ImmI;
            end
            OpcLoad: begin
                regWrite = (funct3 == 3'b010);
                memRead  = (funct3 == 3'b010);
                memWbSel = WbMem;
                op2Sel   = Op2ImmI;
            end
            OpcStore: begin
                memWrite = (funct3 == 3'b010);
                op2Sel   = Op2ImmS;
            end
            OpcBranch: begin
                isBeq  = (funct3 == Funct3Beq);
                isBne  = (funct3 == Funct3Bne);
                pcSel  = (isBeq || isBne) ? PcBranchJump : PcPlus4;
                op2Sel = Op2ImmB;
            end
            OpcJal: begin
                pcSel    = PcBranchJump;
                op1Sel   = Op1Pc;
                op2Sel   = Op2ImmJ;
                linkSel  = 1'b1;
                regWrite = 1'b1;
            end
            OpcJalr: begin
                pcSel    = (funct3 == 3'b000) ? PcJalr : PcPlus4;
                op2Sel   = Op2ImmI;
                linkSel  = 1'b1;
                regWrite = (funct3 == 3'b000);
            end
            OpcLui: begin
                op2Sel   = Op2ImmU;
                aluOp    = AluCopy2;
                regWrite = 1'b1;
            end
            OpcAuipc: begin
                op1Sel   = Op1Pc;
                op2Sel   = Op2ImmU;
                regWrite = 1'b1;
            end
            default: begin
                regWrite = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: logic/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage import rv5Pkg::*; (
    input  wire        clk,
    input  wire        rstN,
    input  wire word_t ifPc,
    input  wire word_t ifInstr,
    input  wire word_t rs1Data,
    input  wire word_t rs2Data,
    input  wire        decKill,
    output regAddr_t   rs1Addr,
    output regAddr_t   rs2Addr,
    output regAddr_t   decRd,
    output logic       decRegWrite,
    output word_t      exPc,
    output word_t      exOp1,
    output word_t      exOp2,
    output word_t      exRs2,
    output aluOp_t     exAluOp,
    output pcSel_t     exPcSel,
    output logic       exIsBeq,
    output logic       exIsBne,
    output logic       exLinkSel,
    output memWbSel_t  exMemWbSel,
    output logic       exMemRead,
    output logic       exMemWrite,
    output logic       exRegWrite,
    output regAddr_t   exRd
);

    pcSel_t    pcSel;
    op1Sel_t   op1Sel;
    op2Sel_t   op2Sel;
    aluOp_t    aluOp;
    memWbSel_t memWbSel;
    logic      linkSel, memRead, memWrite, isBeq, isBne;
    word_t     immI, immS, immB, immU, immJ, shamt, op1, op2;

    controlDecoder ctrl_i (
        .instr(ifInstr), .pcSel, .op1Sel, .op2Sel, .aluOp, .linkSel, .memWbSel,
        .memRead, .memWrite, .regWrite(decRegWrite), .isBeq, .isBne
    );

    assign rs1Addr = ifInstr[19:15];
    assign rs2Addr = ifInstr[24:20];
    assign decRd   = ifInstr[11:7];

    assign immI  = {{20{ifInstr[31]}}, ifInstr[31:20]};
    assign immS  = {{20{ifInstr[31]}}, ifInstr[31:25], ifInstr[11:7]};
    assign immB  = {{19{ifInstr[31]}}, ifInstr[31], ifInstr[7], ifInstr[30:25],
                    ifInstr[11:8], 1'b0};
    assign immU  = {ifInstr[31:12], 12'b0};
    assign immJ  = {{11{ifInstr[31]}}, ifInstr[31], ifInstr[19:12], ifInstr[20],
                    ifInstr[30:21], 1'b0};
    assign shamt = {27'b0, ifInstr[24:20]};

    assign op1 = (op1Sel == Op1Pc) ? ifPc : rs1Data;

    always_comb begin
        case (op2Sel)
            Op2Rs2:   op2 = rs2Data;
            Op2ImmI:  op2 = immI;
            Op2ImmS:  op2 = immS;
            Op2ImmB:  op2 = immB;
            Op2ImmU:  op2 = immU;
            Op2ImmJ:  op2 = immJ;
            Op2Shamt: op2 = shamt;
            default:  op2 = '0;
        endcase
    end

    // control half of DEC/EXE
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exAluOp    <= AluAdd;
            exPcSel    <= PcPlus4;
            exIsBeq    <= 1'b0;
            exIsBne    <= 1'b0;
            exLinkSel  <= 1'b0;
            exMemWbSel <= WbAlu;
            exMemRead  <= 1'b0;
            exMemWrite <= 1'b0;
            exRegWrite <= 1'b0;
            exRd       <= '0;
        end else if (decKill) begin
            // a kill turns it into a bubble
            exAluOp    <= AluAdd;
            exPcSel    <= PcPlus4;
            exIsBeq    <= 1'b0;
            exIsBne    <= 1'b0;
            exLinkSel  <= 1'b0;
            exMemWbSel <= WbAlu;
            exMemRead  <= 1'b0;
            exMemWrite <= 1'b0;
            exRegWrite <= 1'b0;
            exRd       <= '0;
        end else begin
            exAluOp    <= aluOp;
            exPcSel    <= pcSel;
            exIsBeq    <= isBeq;
            exIsBne    <= isBne;
            exLinkSel  <= linkSel;
            exMemWbSel <= memWbSel;
            exMemRead  <= memRead;
            exMemWrite <= memWrite;
            exRegWrite <= decRegWrite;
            exRd       <= decRd;
        end
    end

    always_ff @(posedge clk) begin
        exPc  <= ifPc;
        exOp1 <= op1;
        exOp2 <= op2;
        exRs2 <= rs2Data;
    end

endmodule

`default_nettype wire

// File: logic/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage import rv5Pkg::*; (
    input  wire            clk,
    input  wire            rstN,
    input  wire word_t     exPc,
    input  wire word_t     exOp1,
    input  wire word_t     exOp2,
    input  wire word_t     exRs2,
    input  wire aluOp_t    exAluOp,
    input  wire pcSel_t    exPcSel,
    input  wire            exIsBeq,
    input  wire            exIsBne,
    input  wire            exLinkSel,
    input  wire memWbSel_t exMemWbSel,
    input  wire            exMemRead,
    input  wire            exMemWrite,
    input  wire            exRegWrite,
    input  wire regAddr_t  exRd,
    output logic           redirect,
    output word_t          redirectPc,
    output word_t          memAlu,
    output word_t          memRs2,
    output memWbSel_t      memMemWbSel,
    output logic           memMemRead,
    output logic           memMemWrite,
    output logic           memRegWrite,
    output regAddr_t       memRd
);

    word_t aluResult, branchTarget, jalrTarget;
    logic  opEq, condMet;

    always_comb begin
        case (exAluOp)
            AluAdd:   aluResult = exOp1 + exOp2;
            AluSub:   aluResult = exOp1 - exOp2;
            AluAnd:   aluResult = exOp1 & exOp2;
            AluOr:    aluResult = exOp1 | exOp2;
            AluXor:   aluResult = exOp1 ^ exOp2;
            AluSll:   aluResult = exOp1 << exOp2[4:0];
            AluSrl:   aluResult = exOp1 >> exOp2[4:0];
            AluSra:   aluResult = word_t'($signed(exOp1) >>> exOp2[4:0]);
            AluSlt:   aluResult = {31'b0, $signed(exOp1) < $signed(exOp2)};
            AluSltu:  aluResult = {31'b0, exOp1 < exOp2};
            AluCopy2: aluResult = exOp2;
            default:  aluResult = '0;
        endcase
    end

    // branches carry the B immediate in op2, so rs2 comes separately
    assign opEq    = (exOp1 == exRs2);
    assign condMet = exIsBeq ? opEq : (exIsBne ? !opEq : 1'b1);

    assign branchTarget = exPc + exOp2;
    assign jalrTarget   = (exOp1 + exOp2) & ~32'd1;

    assign redirect   = ((exPcSel == PcBranchJump) && condMet) || (exPcSel == PcJalr);
    assign redirectPc = (exPcSel == PcJalr) ? jalrTarget : branchTarget;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            memMemWbSel <= WbAlu;
            memMemRead  <= 1'b0;
            memMemWrite <= 1'b0;
            memRegWrite <= 1'b0;
            memRd       <= '0;
        end else begin
            memMemWbSel <= exMemWbSel;
            memMemRead  <= exMemRead;
            memMemWrite <= exMemWrite;
            memRegWrite <= exRegWrite;
            memRd       <= exRd;
        end
    end

    // jal and jalr write the return address
    always_ff @(posedge clk) begin
        memAlu <= exLinkSel ? exPc + 32'd4 : aluResult;
        memRs2 <= exRs2;
    end

    noReadAndWrite: assert property (@(posedge clk) disable iff (!rstN)
        !(memMemRead && memMemWrite));

endmodule

`default_nettype wire

// File: logic/fetchStage.sv
`timescale 1ns/1ps
`default_nettype none

module fetchStage import rv5Pkg::*; (
    input  wire        clk,
    input  wire        rstN,
    input  wire word_t instruction,
    input  wire        pcWriteEn,
    input  wire        ifKill,
    input  wire        redirect,
    input  wire word_t redirectPc,
    output word_t      pc,
    output word_t      ifPc,
    output word_t      ifInstr
);

    word_t nextPc;

    // taken branch or jump from execute beats the sequential path
    assign nextPc = redirect ? redirectPc : pc + 32'd4;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= ResetPc;
        end else if (pcWriteEn) begin
            pc <= nextPc;
        end
    end

    // killed slot enters decode as a nop
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ifInstr <= NopInstr;
        end else begin
            ifInstr <= ifKill ? NopInstr : instruction;
        end
    end

    always_ff @(posedge clk) begin
        ifPc <= pc;
    end

    // a stall must never swallow a redirect, the target would be lost
    redirectNotHeld: assert property (@(posedge clk) disable iff (!rstN)
        redirect |-> pcWriteEn);

endmodule

`default_nettype wire

// File: logic/hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module hazardUnit import rv5Pkg::*; (
    input  wire word_t    instruction,
    input  wire regAddr_t decRd,
    input  wire           decRegWrite,
    input  wire regAddr_t exRd,
    input  wire           exRegWrite,
    input  wire regAddr_t memRd,
    input  wire           memRegWrite,
    input  wire regAddr_t wbRd,
    input  wire           wbRegWrite,
    input  wire           redirect,
    output logic          pcWriteEn,
    output logic          ifKill,
    output logic          decKill
);

    regAddr_t rs1, rs2;
    logic     stall;

    // raw source fields are checked even for formats without them
    assign rs1 = instruction[19:15];
    assign rs2 = instruction[24:20];

    function automatic logic pending(regAddr_t src, regAddr_t rd, logic we);
        return we && (rd != '0) && (rd == src);
    endfunction

    function automatic logic anyPending(regAddr_t src);
        return pending(src, decRd, decRegWrite) || pending(src, exRd, exRegWrite)
            || pending(src, memRd, memRegWrite) || pending(src, wbRd, wbRegWrite);
    endfunction

    always_comb begin
        stall     = anyPending(rs1) || anyPending(rs2);
        // a redirect drops the stalled instruction anyway
        pcWriteEn = !stall || redirect;
        ifKill    = stall || redirect;
        decKill   = redirect;
    end

endmodule

`default_nettype wire

// File: logic/memWbStage.sv
`timescale 1ns/1ps
`default_nettype none

module memWbStage import rv5Pkg::*; (
    input  wire            clk,
    input  wire            rstN,
    input  wire word_t     memAlu,
    input  wire word_t     memRs2,
    input  wire memWbSel_t memMemWbSel,
    input  wire            memMemRead,
    input  wire            memMemWrite,
    input  wire            memRegWrite,
    input  wire regAddr_t  memRd,
    input  wire word_t     memRdata,
    output word_t          memAddr,
    output word_t          memWdata,
    output logic           memReadEn,
    output logic           memWriteEn,
    output word_t          wbData,
    output regAddr_t       wbRd,
    output logic           wbRegWrite
);

    // data RAM answers within the cycle
    assign memAddr    = memAlu;
    assign memWdata   = memRs2;
    assign memReadEn  = memMemRead;
    assign memWriteEn = memMemWrite;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wbRegWrite <= 1'b0;
            wbRd       <= '0;
        end else begin
            wbRegWrite <= memRegWrite;
            wbRd       <= memRd;
        end
    end

    always_ff @(posedge clk) begin
        wbData <= (memMemWbSel == WbMem) ? memRdata : memAlu;
    end

endmodule

`default_nettype wire

// File: logic/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile import rv5Pkg::*; (
    input  wire           clk,
    input  wire           rstN,
    input  wire regAddr_t rs1Addr,
    input  wire regAddr_t rs2Addr,
    input  wire regAddr_t wbRd,
    input  wire word_t    wbData,
    input  wire           wbRegWrite,
    input  wire regAddr_t dbgReadAddr,
    output word_t         rs1Data,
    output word_t         rs2Data,
    output word_t         dbgReadData
);

    // x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wbRegWrite && wbRd != '0) begin
            regs[wbRd] <= wbData;
        end
    end

    // no write bypass, decode sees the old value
    assign rs1Data     = (rs1Addr == '0) ? '0 : regs[rs1Addr];
    assign rs2Data     = (rs2Addr == '0) ? '0 : regs[rs2Addr];
    assign dbgReadData = (dbgReadAddr == '0) ? '0 : regs[dbgReadAddr];

endmodule

`default_nettype wire

// File: logic/rv5Core.sv
`timescale 1ns/1ps
`default_nettype none

module rv5Core import rv5Pkg::*; (
    input  wire           clk,
    input  wire           rstN,
    output word_t         pc,
    input  wire word_t    instruction,
    output word_t         memAddr,
    output word_t         memWdata,
    output logic          memReadEn,
    output logic          memWriteEn,
    input  wire word_t    memRdata,
    input  wire regAddr_t dbgReadAddr,
    output word_t         dbgReadData
);

    logic      pcWriteEn, ifKill, decKill, redirect;
    word_t     redirectPc, ifPc, ifInstr;
    regAddr_t  rs1Addr, rs2Addr, decRd;
    word_t     rs1Data, rs2Data;
    logic      decRegWrite;

    // decode to execute
    word_t     exPc, exOp1, exOp2, exRs2;
    aluOp_t    exAluOp;
    pcSel_t    exPcSel;
    logic      exIsBeq, exIsBne, exLinkSel, exMemRead, exMemWrite, exRegWrite;
    memWbSel_t exMemWbSel;
    regAddr_t  exRd;

    // execute to memory
    word_t     memAlu, memRs2;
    memWbSel_t memMemWbSel;
    logic      memMemRead, memMemWrite, memRegWrite;
    regAddr_t  memRd;

    // writeback into the register file
    word_t     wbData;
    regAddr_t  wbRd;
    logic      wbRegWrite;

    hazardUnit hazard_i (
        .instruction, .decRd, .decRegWrite, .exRd, .exRegWrite, .memRd, .memRegWrite,
        .wbRd, .wbRegWrite, .redirect, .pcWriteEn, .ifKill, .decKill
    );

    fetchStage fetch_i (
        .clk, .rstN, .instruction, .pcWriteEn, .ifKill, .redirect, .redirectPc,
        .pc, .ifPc, .ifInstr
    );

    regFile regs_i (
        .clk, .rstN, .rs1Addr, .rs2Addr, .wbRd, .wbData, .wbRegWrite, .dbgReadAddr,
        .rs1Data, .rs2Data, .dbgReadData
    );

    decodeStage decode_i (
        .clk, .rstN, .ifPc, .ifInstr, .rs1Data, .rs2Data, .decKill, .rs1Addr, .rs2Addr,
        .decRd, .decRegWrite, .exPc, .exOp1, .exOp2, .exRs2, .exAluOp, .exPcSel,
        .exIsBeq, .exIsBne, .exLinkSel, .exMemWbSel, .exMemRead, .exMemWrite,
        .exRegWrite, .exRd
    );

    executeStage execute_i (
        .clk, .rstN, .exPc, .exOp1, .exOp2, .exRs2, .exAluOp, .exPcSel, .exIsBeq,
        .exIsBne, .exLinkSel, .exMemWbSel, .exMemRead, .exMemWrite, .exRegWrite, .exRd,
        .redirect, .redirectPc, .memAlu, .memRs2, .memMemWbSel, .memMemRead,
        .memMemWrite, .memRegWrite, .memRd
    );

    memWbStage memWb_i (
        .clk, .rstN, .memAlu, .memRs2, .memMemWbSel, .memMemRead, .memMemWrite,
        .memRegWrite, .memRd, .memRdata, .memAddr, .memWdata, .memReadEn, .memWriteEn,
        .wbData, .wbRd, .wbRegWrite
    );

endmodule

`default_nettype wire

// File: logic/rv5Pkg.sv
`default_nettype none

package rv5Pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [3:0]  aluOp_t;
    typedef logic [1:0]  pcSel_t;
    typedef logic        op1Sel_t;
    typedef logic [2:0]  op2Sel_t;
    typedef logic        memWbSel_t;

    // addi x0, x0, 0
    localparam word_t NopInstr = 32'h0000_0013;
    localparam word_t ResetPc  = 32'h0000_0000;

    localparam aluOp_t AluAdd   = 4'd0;
    localparam aluOp_t AluSub   = 4'd1;
    localparam aluOp_t AluAnd   = 4'd2;
    localparam aluOp_t AluOr    = 4'd3;
    localparam aluOp_t AluXor   = 4'd4;
    localparam aluOp_t AluSll   = 4'd5;
    localparam aluOp_t AluSrl   = 4'd6;
    localparam aluOp_t AluSra   = 4'd7;
    localparam aluOp_t AluSlt   = 4'd8;
    localparam aluOp_t AluSltu  = 4'd9;
    // second operand straight through, used by lui
    localparam aluOp_t AluCopy2 = 4'd10;

    localparam pcSel_t PcPlus4      = 2'd0;
    localparam pcSel_t PcBranchJump = 2'd1;
    localparam pcSel_t PcJalr       = 2'd2;

    localparam op1Sel_t Op1Pc  = 1'b0;
    localparam op1Sel_t Op1Rs1 = 1'b1;

    localparam op2Sel_t Op2Rs2   = 3'd0;
    localparam op2Sel_t Op2ImmI  = 3'd1;
    localparam op2Sel_t Op2ImmS  = 3'd2;
    localparam op2Sel_t Op2ImmB  = 3'd3;
    localparam op2Sel_t Op2ImmU  = 3'd4;
    localparam op2Sel_t Op2ImmJ  = 3'd5;
    localparam op2Sel_t Op2Shamt = 3'd6;

    localparam memWbSel_t WbAlu = 1'b0;
    localparam memWbSel_t WbMem = 1'b1;

    // major opcodes
    localparam logic [6:0] OpcOp     = 7'b0110011;
    localparam logic [6:0] OpcOpImm  = 7'b0010011;
    localparam logic [6:0] OpcLoad   = 7'b0000011;
    localparam logic [6:0] OpcStore  = 7'b0100011;
    localparam logic [6:0] OpcBranch = 7'b1100011;
    localparam logic [6:0] OpcJal    = 7'b1101111;
    localparam logic [6:0] OpcJalr   = 7'b1100111;
    localparam logic [6:0] OpcLui    = 7'b0110111;
    localparam logic [6:0] OpcAuipc  = 7'b0010111;

    localparam logic [2:0] Funct3Beq = 3'b000;
    localparam logic [2:0] Funct3Bne = 3'b001;

endpackage

`default_nettype wire

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module rv5CoreTb -f files.f \
    -o simv > build.log 2>&1 \
    && ./obj_dir/simv > sim.log 2>&1 \
    || echo ">>> FAIL" >> sim.log
grep -q ">>> PASS" sim.log || echo ">>> FAIL" >> sim.log
cat sim.log
grep -q ">>> FAIL" sim.log && exit 1 || exit 0

// File: include/tbIsaModel.svh
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

// 16-bit Fibonacci LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

function automatic word_t drawBits(input int n);
    word_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsrState = lfsrNext(lfsrState);
        v = {v[30:0], lfsrState[0]};
    end
    return v;
endfunction

function automatic word_t encR(input logic [6:0] f7, input regAddr_t rs2, input regAddr_t rs1,
                               input logic [2:0] f3, input regAddr_t rd);
    return {f7, rs2, rs1, f3, rd, OpcOp};
endfunction

function automatic word_t encI(input logic [11:0] imm, input regAddr_t rs1,
                               input logic [2:0] f3, input regAddr_t rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic word_t encS(input logic [11:0] imm, input regAddr_t rs2, input regAddr_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OpcStore};
endfunction

function automatic word_t encB(input logic [12:0] imm, input regAddr_t rs2, input regAddr_t rs1,
                               input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OpcBranch};
endfunction

function automatic word_t encU(input logic [19:0] imm, input regAddr_t rd, input logic [6:0] opc);
    return {imm, rd, opc};
endfunction

function automatic word_t encJ(input logic [20:0] imm, input regAddr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OpcJal};
endfunction

// RV32I integer op by funct3, alt is instruction bit 30
function automatic word_t computeAlu(input logic [2:0] f3, input logic alt,
                                     input word_t a, input word_t b);
    case (f3)
        3'd0:    return alt ? a - b : a + b;
        3'd1:    return a << b[4:0];
        3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3:    return (a < b) ? 32'd1 : 32'd0;
        3'd4:    return a ^ b;
        3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

`endif

// File: verif/rv5CoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module rv5CoreTb import rv5Pkg::*; ();

    logic        clk, rstN;
    word_t       pc, instruction, memAddr, memWdata, memRdata, dbgReadData;
    logic        memReadEn, memWriteEn;
    regAddr_t    dbgReadAddr;
    logic [15:0] lfsrState;
    word_t       rom [0:255];
    word_t       ram [0:255];
    word_t       expRam [0:255];
    word_t       expRegs [0:31];
    word_t       storeAddr [$];
    word_t       storeData [$];
    word_t       loadAddr [$];
    word_t       haltPc;
    int          progLen, errors, checks, cycles, haltCount;

    `include "tbIsaModel.svh"

    rv5Core dut_i (
        .clk, .rstN, .pc, .instruction, .memAddr, .memWdata, .memReadEn, .memWriteEn,
        .memRdata, .dbgReadAddr, .dbgReadData
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    assign instruction = rom[pc[9:2]];
    assign memRdata    = ram[memAddr[9:2]];

    always @(posedge clk) begin
        if (memWriteEn) begin
            ram[memAddr[9:2]] <= memWdata;
        end
    end

    function automatic word_t fillWord(input int i);
        return (word_t'(i) * 32'h0001_0203) ^ 32'hC3A5_0000;
    endfunction

    task automatic checkEq(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic put(input word_t w);
        rom[progLen] = w;
        progLen++;
    endtask

    // random ALU work mixed with fixed memory, branch and jump templates
    task automatic buildProgram();
        word_t    f3, off;
        word_t    kind;
        regAddr_t rd, ra, rb;
        progLen = 0;
        while (progLen < 60) begin
            kind = drawBits(3);
            rd   = regAddr_t'(drawBits(3));
            ra   = regAddr_t'(drawBits(3));
            rb   = regAddr_t'(drawBits(3));
            off  = drawBits(8) << 2;
            case (kind)
                0, 1: begin
                    f3 = drawBits(3);
                    put(encR(((f3 == 0 || f3 == 5) && drawBits(1) != 0) ? 7'h20 : 7'h00,
                             rb, ra, f3[2:0], rd));
                end
                2: begin
                    f3  = drawBits(3);
                    off = drawBits(12);
                    if (f3 == 1 || f3 == 5) begin
                        off = {20'b0, (f3 == 5 && drawBits(1) != 0) ? 7'h20 : 7'h00, off[4:0]};
                    end
                    put(encI(off[11:0], ra, f3[2:0], rd, OpcOpImm));
                end
                3: begin
                    off = drawBits(20);
                    put(encU(off[19:0], rd, (drawBits(1) != 0) ? OpcLui : OpcAuipc));
                end
                4: begin
                    // store, reload and use the loaded value at once
                    put(encS(off[11:0], rb, 5'd0));
                    put(encI(off[11:0], 5'd0, 3'b010, rd, OpcLoad));
                    put(encR(7'h00, ra, rd, 3'b000, rb));
                end
                5: begin
                    put(encI(off[11:0], 5'd0, 3'b010, rd, OpcLoad));
                    put(encI(12'd1, rd, 3'b000, rd, OpcOpImm));
                end
                6: begin
                    if (drawBits(1) != 0) begin
                        rb = ra;
                    end
                    put(encB(13'd8, rb, ra, (drawBits(1) != 0) ? Funct3Bne : Funct3Beq));
                    put(encI(12'h7a5, 5'd0, 3'b000, rb, OpcOpImm));
                end
                default: begin
                    if (drawBits(1) != 0) begin
                        put(encJ(21'd8, rd));
                    end else begin
                        ra = regAddr_t'(drawBits(2)) + 5'd1;
                        put(encU(20'd0, ra, OpcAuipc));
                        put(encI(12'd12, ra, 3'b000, rd, OpcJalr));
                    end
                    // only reached when the jump is lost
                    put(encI(12'h35c, 5'd0, 3'b000, ra, OpcOpImm));
                end
            endcase
        end
        haltPc = word_t'(progLen) * 4;
        put(encJ(21'd0, 5'd0));
    endtask

    // sequential ISA run of the same program
    task automatic runModel();
        word_t p, nextP, ins, a, b, immI, immS, immB, immJ, immU, addr, res;
        logic  wr, taken;
        int    steps;
        for (int i = 0; i < 32; i++) begin
            expRegs[i] = '0;
        end
        p     = '0;
        steps = 0;
        while (p != haltPc && steps < 1000) begin
            ins   = rom[p[9:2]];
            a     = expRegs[ins[19:15]];
            b     = expRegs[ins[24:20]];
            immI  = {{20{ins[31]}}, ins[31:20]};
            immS  = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            immB  = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            immJ  = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            immU  = {ins[31:12], 12'b0};
            nextP = p + 4;
            wr    = 1'b1;
            res   = '0;
            case (ins[6:0])
                OpcOp:    res = computeAlu(ins[14:12], ins[30], a, b);
                OpcOpImm: res = computeAlu(ins[14:12], ins[14:12] == 3'b101 && ins[30], a, immI);
                OpcLui:   res = immU;
                OpcAuipc: res = p + immU;
                OpcLoad: begin
                    addr = a + immI;
                    res  = expRam[addr[9:2]];
                    loadAddr.push_back(addr);
                end
                OpcStore: begin
                    wr   = 1'b0;
                    addr = a + immS;
                    expRam[addr[9:2]] = b;
                    storeAddr.push_back(addr);
                    storeData.push_back(b);
                end
                OpcBranch: begin
                    wr    = 1'b0;
                    taken = (ins[14:12] == Funct3Beq) ? (a == b) : (a != b);
                    if (taken) begin
                        nextP = p + immB;
                    end
                end
                OpcJal: begin
                    res   = p + 4;
                    nextP = p + immJ;
                end
                OpcJalr: begin
                    res   = p + 4;
                    nextP = (a + immI) & ~32'd1;
                end
                default: wr = 1'b0;
            endcase
            if (wr && ins[11:7] != 5'd0) begin
                expRegs[ins[11:7]] = res;
            end
            p = nextP;
            steps++;
        end
    endtask

    task automatic checkReset();
        checkEq("memReadEn", {31'b0, memReadEn}, 32'd0);
        checkEq("memWriteEn", {31'b0, memWriteEn}, 32'd0);
        checkEq("pc", pc, ResetPc);
    endtask

    always @(negedge clk) begin
        // the halt jal refetches its own address every third cycle
        if (!rstN || pc < haltPc || pc > haltPc + 32'd8) begin
            haltCount = 0;
        end else begin
            haltCount++;
        end
        if (rstN && memWriteEn) begin
            if (storeAddr.size() == 0) begin
                errors++;
                $display("store at time %0t was not expected by the model", $time);
            end else begin
                checkEq("memAddr", memAddr, storeAddr.pop_front());
                checkEq("memWdata", memWdata, storeData.pop_front());
            end
        end
        if (rstN && memReadEn) begin
            if (loadAddr.size() == 0) begin
                errors++;
                $display("load at time %0t was not expected by the model", $time);
            end else begin
                checkEq("memAddr", memAddr, loadAddr.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (progLen > 0 && cycles > 8 * progLen + 100) begin
            $display("timeout after %0d cycles, the core never settled in the halt loop", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        rstN        = 1'b0;
        dbgReadAddr = '0;
        lfsrState   = 16'd48329;
        errors      = 0;
        checks      = 0;
        cycles      = 0;
        haltCount   = 0;
        progLen     = 0;
        for (int i = 0; i < 256; i++) begin
            rom[i]    = NopInstr;
            ram[i]    = fillWord(i);
            expRam[i] = fillWord(i);
        end
        buildProgram();
        runModel();
        repeat (5) begin
            @(negedge clk);
            checkReset();
        end
        @(posedge clk);
        #1 rstN = 1'b1;
        @(negedge clk);
        checkReset();
        wait (haltCount >= 8);
        for (int r = 0; r < 32; r++) begin
            @(posedge clk);
            #1 dbgReadAddr = regAddr_t'(r);
            @(negedge clk);
            checkEq($sformatf("x%0d", r), dbgReadData, expRegs[r]);
        end
        for (int i = 0; i < 256; i++) begin
            checkEq($sformatf("ram[%0d]", i), ram[i], expRam[i]);
        end
        if (storeAddr.size() != 0) begin
            errors++;
            $display("%0d expected stores never reached the memory port", storeAddr.size());
        end
        if (loadAddr.size() != 0) begin
            errors++;
            $display("%0d expected loads never reached the memory port", loadAddr.size());
        end
        $display("checks %0d, errors %0d, cycles %0d", checks, errors, cycles);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
